// ==== rtl/gaa_pkg.sv ====
package gaa_pkg;

	localparam int NUM_IDV_MAX  = 128;
	localparam int BANK_BYTES   = 16;
	localparam int NODE_ADDR_W  = 10;
	localparam int SDRAM_ADDR_W = 25;

	// results start halfway through the sdram word space
	localparam logic [SDRAM_ADDR_W-1:0] RESULT_BASE = 25'h100_0000;

	// host register map
	localparam logic [3:0] REG_EDGES0 = 4'd0;
	localparam logic [3:0] REG_EDGES1 = 4'd1;
	localparam logic [3:0] REG_EDGES2 = 4'd2;
	localparam logic [3:0] REG_EDGES3 = 4'd3;
	localparam logic [3:0] REG_NODES0 = 4'd4;
	localparam logic [3:0] REG_NODES1 = 4'd5;
	localparam logic [3:0] REG_IDV    = 4'd6;
	localparam logic [3:0] REG_POP    = 4'd7;
	localparam logic [3:0] REG_START  = 4'd8;

	typedef logic [NODE_ADDR_W-1:0]  node_addr_t;
	typedef logic [SDRAM_ADDR_W-1:0] sdram_addr_t;
	typedef logic [15:0]             sdram_word_t;
	typedef logic [NUM_IDV_MAX-1:0]  part_row_t;
	typedef logic [31:0]             edge_count_t;
	typedef logic [15:0]             node_count_t;
	typedef logic [7:0]              idv_count_t;
	typedef logic [23:0]             cut_count_t;
	typedef logic [7:0]              host_byte_t;

	typedef enum logic [3:0] {
		IDLE, READ_N1, READ_N2, LOOKUP, LOOKUP_WAIT,
		ACCUMULATE, WRITE_RESULT, WRITE_WAIT, DONE
	} fit_state_t;

endpackage

// ==== rtl/host_regs.sv ====
`timescale 1ns/1ps

module host_regs
	import gaa_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic [3:0]  hps_address,
	input  logic        hps_chipselect,
	input  logic        hps_write,
	input  host_byte_t  hps_writedata,
	input  logic        done,
	output logic        hps_waitrequest,
	output edge_count_t num_edges,
	output node_count_t num_nodes,
	output idv_count_t  num_idv,
	output logic        start,
	output logic        pop_wr_en,
	output node_addr_t  pop_wr_addr,
	output part_row_t   pop_wr_row
);

	logic [$clog2(BANK_BYTES)-1:0] byte_cnt;
	node_addr_t node_cnt;
	logic busy;
	logic host_wr;
	logic row_last;

	// writes are dropped while a run is in progress
	assign host_wr = hps_chipselect && hps_write && !busy;
	assign row_last = (byte_cnt == BANK_BYTES - 1);

	always_ff @(posedge clk) begin
		if (reset) begin
			hps_waitrequest <= 1'b1;
			busy <= 1'b0;
			start <= 1'b0;
			pop_wr_en <= 1'b0;
			num_edges <= '0;
			num_nodes <= '0;
			num_idv <= '0;
			byte_cnt <= '0;
			node_cnt <= '0;
		end else begin
			start <= 1'b0;
			pop_wr_en <= 1'b0;
			if (done) begin
				busy <= 1'b0;
				hps_waitrequest <= 1'b0;
			end else if (host_wr) begin
				hps_waitrequest <= 1'b0;
				case (hps_address)
					REG_EDGES0: num_edges[7:0] <= hps_writedata;
					REG_EDGES1: num_edges[15:8] <= hps_writedata;
					REG_EDGES2: num_edges[23:16] <= hps_writedata;
					REG_EDGES3: num_edges[31:24] <= hps_writedata;
					REG_NODES0: num_nodes[7:0] <= hps_writedata;
					REG_NODES1: num_nodes[15:8] <= hps_writedata;
					REG_IDV: num_idv <= hps_writedata;
					REG_POP: begin
						byte_cnt <= byte_cnt + 1'b1;
						if (row_last) begin
							pop_wr_en <= 1'b1;
							// wrap back to node 0 after the last node
							if (node_count_t'(node_cnt) + 1'b1 >= num_nodes)
								node_cnt <= '0;
							else
								node_cnt <= node_cnt + 1'b1;
						end
					end
					REG_START: begin
						start <= 1'b1;
						busy <= 1'b1;
						hps_waitrequest <= 1'b1;
						byte_cnt <= '0;
						node_cnt <= '0;
					end
					default: begin
						num_edges <= '0;
						num_nodes <= '0;
						num_idv <= '0;
						byte_cnt <= '0;
						node_cnt <= '0;
					end
				endcase
			end
		end
	end

	// byte i carries individuals 8i..8i+7
	always_ff @(posedge clk) begin
		if (host_wr && hps_address == REG_POP) begin
			pop_wr_row[byte_cnt*$bits(host_byte_t) +: $bits(host_byte_t)] <= hps_writedata;
			if (row_last)
				pop_wr_addr <= node_cnt;
		end
	end

	// the controller only finishes a run that was started here
	a_done_busy: assert property (@(posedge clk) disable iff (reset)
		done |-> busy);

endmodule

// ==== rtl/partition_mem.sv ====
`timescale 1ns/1ps

module partition_mem
	import gaa_pkg::*;
(
	input  logic       clk,
	input  logic       pop_wr_en,
	input  node_addr_t pop_wr_addr,
	input  part_row_t  pop_wr_row,
	input  node_addr_t lookup_a,
	input  node_addr_t lookup_b,
	output part_row_t  row_a,
	output part_row_t  row_b
);

	part_row_t mem [2**NODE_ADDR_W];
	node_addr_t addr_a;

	// port a is shared by population loads and the first lookup
	assign addr_a = pop_wr_en ? pop_wr_addr : lookup_a;

	always_ff @(posedge clk) begin
		if (pop_wr_en)
			mem[addr_a] <= pop_wr_row;
		row_a <= mem[addr_a];
	end

	always_ff @(posedge clk) begin
		row_b <= mem[lookup_b];
	end

endmodule

// ==== rtl/cut_counters.sv ====
`timescale 1ns/1ps

module cut_counters
	import gaa_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  logic        acc_en,
	input  part_row_t   row_a,
	input  part_row_t   row_b,
	input  idv_count_t  sel_idv,
	output sdram_word_t sel_cut_sat
);

	localparam int IDX_W = $clog2(NUM_IDV_MAX);

	cut_count_t cnt [NUM_IDV_MAX];
	part_row_t diff;
	logic [IDX_W-1:0] sel_idx;
	cut_count_t sel_cnt;

	// an edge is cut for an individual when its two nodes sit in different halves
	assign diff = row_a ^ row_b;

	always_ff @(posedge clk) begin
		if (reset || start) begin
			for (int i = 0; i < NUM_IDV_MAX; i++)
				cnt[i] <= '0;
		end else if (acc_en) begin
			for (int i = 0; i < NUM_IDV_MAX; i++)
				cnt[i] <= cnt[i] + cut_count_t'(diff[i]);
		end
	end

	assign sel_idx = sel_idv[IDX_W-1:0];
	assign sel_cnt = cnt[sel_idx];

	// clamp to what fits in one sdram word
	assign sel_cut_sat = (|sel_cnt[$bits(cut_count_t)-1:$bits(sdram_word_t)]) ?
		'1 : sel_cnt[$bits(sdram_word_t)-1:0];

endmodule

// ==== rtl/fitness_ctrl.sv ====
`timescale 1ns/1ps

module fitness_ctrl
	import gaa_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  edge_count_t num_edges,
	input  idv_count_t  num_idv,
	output sdram_addr_t sdram_address,
	output logic [1:0]  sdram_byteenable_n,
	output logic        sdram_chipselect,
	output logic        sdram_read_n,
	output logic        sdram_write_n,
	output sdram_word_t sdram_writedata,
	input  sdram_word_t sdram_readdata,
	input  logic        sdram_waitrequest,
	output node_addr_t  lookup_a,
	output node_addr_t  lookup_b,
	output logic        acc_en,
	output idv_count_t  sel_idv,
	input  sdram_word_t sel_cut_sat,
	output logic        done
);

	fit_state_t state;
	edge_count_t edge_cnt;
	idv_count_t idv_cnt;
	node_addr_t n1;
	node_addr_t n2;
	logic last_edge;
	logic more_idv;

	assign acc_en = (state == ACCUMULATE);
	assign done = (state == DONE);
	assign sel_idv = idv_cnt;
	assign last_edge = (edge_cnt + 1'b1 >= num_edges);
	assign more_idv = (idv_cnt < num_idv) && (idv_cnt < NUM_IDV_MAX);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			edge_cnt <= '0;
			idv_cnt <= '0;
			sdram_address <= '0;
			sdram_byteenable_n <= 2'b11;
			sdram_chipselect <= 1'b0;
			sdram_read_n <= 1'b1;
			sdram_write_n <= 1'b1;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						edge_cnt <= '0;
						idv_cnt <= '0;
						if (num_edges == '0) begin
							state <= WRITE_RESULT;
						end else begin
							// edge k sits at words 2k and 2k+1
							sdram_address <= '0;
							sdram_byteenable_n <= 2'b00;
							sdram_chipselect <= 1'b1;
							sdram_read_n <= 1'b0;
							state <= READ_N1;
						end
					end
				end
				READ_N1: begin
					if (!sdram_waitrequest) begin
						n1 <= sdram_readdata[NODE_ADDR_W-1:0];
						sdram_address <= sdram_address + 1'b1;
						state <= READ_N2;
					end
				end
				READ_N2: begin
					if (!sdram_waitrequest) begin
						n2 <= sdram_readdata[NODE_ADDR_W-1:0];
						sdram_byteenable_n <= 2'b11;
						sdram_chipselect <= 1'b0;
						sdram_read_n <= 1'b1;
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					lookup_a <= n1;
					lookup_b <= n2;
					state <= LOOKUP_WAIT;
				end
				// rows come back one cycle after the lookup address
				LOOKUP_WAIT: state <= ACCUMULATE;
				ACCUMULATE: begin
					if (last_edge) begin
						state <= WRITE_RESULT;
					end else begin
						edge_cnt <= edge_cnt + 1'b1;
						sdram_address <= sdram_addr_t'({edge_cnt + 1'b1, 1'b0});
						sdram_byteenable_n <= 2'b00;
						sdram_chipselect <= 1'b1;
						sdram_read_n <= 1'b0;
						state <= READ_N1;
					end
				end
				WRITE_RESULT: begin
					if (more_idv) begin
						sdram_address <= RESULT_BASE + idv_cnt;
						sdram_writedata <= sel_cut_sat;
						sdram_byteenable_n <= 2'b00;
						sdram_chipselect <= 1'b1;
						sdram_write_n <= 1'b0;
						state <= WRITE_WAIT;
					end else begin
						state <= DONE;
					end
				end
				WRITE_WAIT: begin
					if (!sdram_waitrequest) begin
						sdram_byteenable_n <= 2'b11;
						sdram_chipselect <= 1'b0;
						sdram_write_n <= 1'b1;
						idv_cnt <= idv_cnt + 1'b1;
						state <= WRITE_RESULT;
					end
				end
				DONE: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	a_no_rd_wr: assert property (@(posedge clk) disable iff (reset)
		!(!sdram_read_n && !sdram_write_n));

	// a stalled command keeps its address until the slave takes it
	a_addr_hold: assert property (@(posedge clk) disable iff (reset)
		(!sdram_read_n || !sdram_write_n) && sdram_waitrequest |=> $stable(sdram_address));

endmodule

// ==== rtl/gaa_fitness.sv ====
`timescale 1ns/1ps

module gaa_fitness
	import gaa_pkg::*;
(
	input  logic        clk,
	input  logic        reset,

	input  logic [3:0]  hps_address,
	input  logic        hps_chipselect,
	input  logic        hps_write,
	input  host_byte_t  hps_writedata,
	output logic        hps_waitrequest,

	output sdram_addr_t sdram_address,
	output logic [1:0]  sdram_byteenable_n,
	output logic        sdram_chipselect,
	output logic        sdram_read_n,
	output logic        sdram_write_n,
	output sdram_word_t sdram_writedata,
	input  sdram_word_t sdram_readdata,
	input  logic        sdram_waitrequest
);

	edge_count_t num_edges;
	idv_count_t  num_idv;
	logic        start;
	logic        done;
	logic        pop_wr_en;
	node_addr_t  pop_wr_addr;
	part_row_t   pop_wr_row;
	node_addr_t  lookup_a;
	node_addr_t  lookup_b;
	part_row_t   row_a;
	part_row_t   row_b;
	logic        acc_en;
	idv_count_t  sel_idv;
	sdram_word_t sel_cut_sat;

	// node count only bounds the population write pointer inside the register block
	host_regs u_host_regs (
		.clk(clk), .reset(reset),
		.hps_address(hps_address), .hps_chipselect(hps_chipselect),
		.hps_write(hps_write), .hps_writedata(hps_writedata), .done(done),
		.hps_waitrequest(hps_waitrequest), .num_edges(num_edges), .num_nodes(),
		.num_idv(num_idv), .start(start), .pop_wr_en(pop_wr_en),
		.pop_wr_addr(pop_wr_addr), .pop_wr_row(pop_wr_row)
	);

	partition_mem u_partition_mem (
		.clk(clk), .pop_wr_en(pop_wr_en), .pop_wr_addr(pop_wr_addr),
		.pop_wr_row(pop_wr_row), .lookup_a(lookup_a), .lookup_b(lookup_b),
		.row_a(row_a), .row_b(row_b)
	);

	cut_counters u_cut_counters (
		.clk(clk), .reset(reset), .start(start), .acc_en(acc_en),
		.row_a(row_a), .row_b(row_b), .sel_idv(sel_idv), .sel_cut_sat(sel_cut_sat)
	);

	fitness_ctrl u_fitness_ctrl (
		.clk(clk), .reset(reset), .start(start),
		.num_edges(num_edges), .num_idv(num_idv),
		.sdram_address(sdram_address), .sdram_byteenable_n(sdram_byteenable_n),
		.sdram_chipselect(sdram_chipselect), .sdram_read_n(sdram_read_n),
		.sdram_write_n(sdram_write_n), .sdram_writedata(sdram_writedata),
		.sdram_readdata(sdram_readdata), .sdram_waitrequest(sdram_waitrequest),
		.lookup_a(lookup_a), .lookup_b(lookup_b), .acc_en(acc_en),
		.sel_idv(sel_idv), .sel_cut_sat(sel_cut_sat), .done(done)
	);

endmodule

// ==== verif/sdram_model.sv ====
`timescale 1ns/1ps

module sdram_model
	import gaa_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        stall_en,
	input  sdram_addr_t address,
	input  logic [1:0]  byteenable_n,
	input  logic        chipselect,
	input  logic        read_n,
	input  logic        write_n,
	input  sdram_word_t writedata,
	output sdram_word_t readdata,
	output logic        waitrequest
);

	localparam int MEM_W = 18;

	sdram_word_t mem [2**MEM_W];
	sdram_word_t results [NUM_IDV_MAX];
	int          wr_count = 0;
	int          seed = 32'hadbc;
	logic [31:0] roll;
	sdram_addr_t offset;
	logic [$clog2(NUM_IDV_MAX)-1:0] res_idx;

	// read data is driven only during a read and taken in a cycle without stall
	assign readdata = (chipselect && !read_n) ? mem[address[MEM_W-1:0]] : '1;
	assign offset = address - RESULT_BASE;
	assign res_idx = offset[$clog2(NUM_IDV_MAX)-1:0];

	always @(posedge clk) begin
		if (reset) begin
			waitrequest <= 1'b0;
		end else begin
			roll = $random(seed);
			waitrequest <= stall_en && roll[0];
			if (chipselect && !write_n && !waitrequest) begin
				wr_count++;
				// only the enabled bytes land in the result word
				if (address >= RESULT_BASE && offset < NUM_IDV_MAX) begin
					if (!byteenable_n[0])
						results[res_idx][7:0] = writedata[7:0];
					if (!byteenable_n[1])
						results[res_idx][15:8] = writedata[15:8];
				end
			end
		end
	end

	task automatic load_word(input sdram_addr_t addr, input sdram_word_t data);
		mem[addr[MEM_W-1:0]] = data;
	endtask

	// each result slot gets a marker that depends on its index
	task automatic clear_results();
		for (int i = 0; i < NUM_IDV_MAX; i++)
			results[i] = sdram_word_t'(16'hc000 + i);
	endtask

	function automatic sdram_word_t result_at(input idv_count_t idv);
		return results[idv[$clog2(NUM_IDV_MAX)-1:0]];
	endfunction

endmodule

// ==== verif/tb_gaa_fitness.sv ====
`timescale 1ns/1ps

module tb_gaa_fitness
	import gaa_pkg::*;
();

	localparam int TD_WORDS = 256;
	localparam int EDGES_MAX = 64;

	logic        clk;
	logic        reset;
	logic [3:0]  hps_address;
	logic        hps_chipselect;
	logic        hps_write;
	host_byte_t  hps_writedata;
	logic        hps_waitrequest;
	sdram_addr_t sdram_address;
	logic [1:0]  sdram_byteenable_n;
	logic        sdram_chipselect;
	logic        sdram_read_n;
	logic        sdram_write_n;
	sdram_word_t sdram_writedata;
	sdram_word_t sdram_readdata;
	logic        sdram_waitrequest;
	logic        stall_en;

	logic [127:0] td [TD_WORDS];
	int           td_pos;
	int           checks;
	int           errors;
	int           runs;
	logic         aborted;
	part_row_t    rows [2**NODE_ADDR_W];
	sdram_word_t  edge_a [EDGES_MAX];
	sdram_word_t  edge_b [EDGES_MAX];

	gaa_fitness u_gaa_fitness (
		.clk(clk), .reset(reset),
		.hps_address(hps_address), .hps_chipselect(hps_chipselect),
		.hps_write(hps_write), .hps_writedata(hps_writedata),
		.hps_waitrequest(hps_waitrequest),
		.sdram_address(sdram_address), .sdram_byteenable_n(sdram_byteenable_n),
		.sdram_chipselect(sdram_chipselect), .sdram_read_n(sdram_read_n),
		.sdram_write_n(sdram_write_n), .sdram_writedata(sdram_writedata),
		.sdram_readdata(sdram_readdata), .sdram_waitrequest(sdram_waitrequest)
	);

	sdram_model u_sdram_model (
		.clk(clk), .reset(reset), .stall_en(stall_en),
		.address(sdram_address), .byteenable_n(sdram_byteenable_n),
		.chipselect(sdram_chipselect),
		.read_n(sdram_read_n), .write_n(sdram_write_n), .writedata(sdram_writedata),
		.readdata(sdram_readdata), .waitrequest(sdram_waitrequest)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [127:0] take();
		take = td[td_pos];
		td_pos++;
	endfunction

	task automatic check_fitness(input idv_count_t idv, input sdram_word_t got,
		input sdram_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: fitness of individual %0d is %h, expected %h",
				$time, idv, got, exp);
		end
	endtask

	task automatic check_count(input idv_count_t got, input idv_count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %0d result writes, expected %0d", $time, got, exp);
		end
	endtask

	task automatic check_level(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic host_write(input logic [3:0] addr, input host_byte_t data);
		@(posedge clk);
		hps_address <= addr;
		hps_chipselect <= 1'b1;
		hps_write <= 1'b1;
		hps_writedata <= data;
		@(posedge clk);
		hps_chipselect <= 1'b0;
		hps_write <= 1'b0;
	endtask

	// listed edges repeat up to n_edges, so each one counts occ times
	function automatic sdram_word_t expected_fitness(input int idv, input edge_count_t n_edges,
		input int listed);
		longint     cut;
		longint     occ;
		node_addr_t a;
		node_addr_t b;
		cut = 0;
		for (int k = 0; k < listed; k++) begin
			a = edge_a[k][NODE_ADDR_W-1:0];
			b = edge_b[k][NODE_ADDR_W-1:0];
			occ = longint'(n_edges) / listed;
			if (k < longint'(n_edges) % listed)
				occ++;
			if (rows[a][idv] != rows[b][idv])
				cut += occ;
		end
		if (cut > 65535)
			return 16'hffff;
		return sdram_word_t'(cut);
	endfunction

	task automatic wait_run_end(input int run, input longint limit, output logic timed_out);
		longint cycles;
		cycles = 0;
		while (hps_waitrequest && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		timed_out = hps_waitrequest;
		if (timed_out) begin
			errors++;
			$display("timeout: run %0d did not finish within %0d cycles", run, limit);
		end
	endtask

	task automatic run_case(input int run, output logic timed_out);
		edge_count_t n_edges;
		node_count_t n_nodes;
		idv_count_t  n_idv;
		logic        stall;
		int          listed;
		sdram_word_t stated0;
		int          base_count;
		n_edges = edge_count_t'(take());
		n_nodes = node_count_t'(take());
		n_idv = idv_count_t'(take());
		stall = (take() != '0);
		listed = int'(take());
		stated0 = sdram_word_t'(take());
		for (int n = 0; n < int'(n_nodes); n++)
			rows[n] = part_row_t'(take());
		for (int k = 0; k < listed; k++) begin
			edge_a[k] = sdram_word_t'(take());
			edge_b[k] = sdram_word_t'(take());
		end
		// edge k sits at words 2k and 2k+1
		for (longint k = 0; k < longint'(n_edges); k++) begin
			u_sdram_model.load_word(sdram_addr_t'(2 * k), edge_a[k % listed]);
			u_sdram_model.load_word(sdram_addr_t'(2 * k + 1), edge_b[k % listed]);
		end
		@(posedge clk);
		stall_en <= stall;
		host_write(REG_EDGES0, n_edges[7:0]);
		@(negedge clk);
		check_level("hps_waitrequest after a register write", hps_waitrequest, 1'b0);
		host_write(REG_EDGES1, n_edges[15:8]);
		host_write(REG_EDGES2, n_edges[23:16]);
		host_write(REG_EDGES3, n_edges[31:24]);
		host_write(REG_NODES0, n_nodes[7:0]);
		host_write(REG_NODES1, n_nodes[15:8]);
		host_write(REG_IDV, n_idv);
		for (int n = 0; n < int'(n_nodes); n++)
			for (int b = 0; b < BANK_BYTES; b++)
				host_write(REG_POP, rows[n][8*b +: 8]);
		base_count = u_sdram_model.wr_count;
		u_sdram_model.clear_results();
		host_write(REG_START, 8'h01);
		@(negedge clk);
		check_level("hps_waitrequest during a run", hps_waitrequest, 1'b1);
		wait_run_end(run, 16 * longint'(n_edges) + 64 * longint'(n_idv) + 1000, timed_out);
		if (!timed_out) begin
			check_count(idv_count_t'(u_sdram_model.wr_count - base_count), n_idv);
			for (int i = 0; i < int'(n_idv); i++)
				check_fitness(idv_count_t'(i), u_sdram_model.result_at(idv_count_t'(i)),
					expected_fitness(i, n_edges, listed));
			// individual 0 against the value written in the data file
			check_fitness('0, u_sdram_model.result_at('0), stated0);
		end
	endtask

	initial begin
		checks = 0;
		errors = 0;
		td_pos = 0;
		aborted = 1'b0;
		reset = 1'b1;
		stall_en = 1'b0;
		hps_address = '0;
		hps_chipselect = 1'b0;
		hps_write = 1'b0;
		hps_writedata = '0;
		$readmemh("verif/gaa_testdata.txt", td);
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_level("hps_waitrequest after reset", hps_waitrequest, 1'b1);
		check_level("sdram_read_n after reset", sdram_read_n, 1'b1);
		check_level("sdram_write_n after reset", sdram_write_n, 1'b1);
		check_level("sdram_chipselect after reset", sdram_chipselect, 1'b0);
		runs = int'(take());
		for (int r = 0; r < runs && !aborted; r++)
			run_case(r, aborted);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== gaa_fitness.f ====
rtl/gaa_pkg.sv
rtl/host_regs.sv
rtl/partition_mem.sv
rtl/cut_counters.sv
rtl/fitness_ctrl.sv
rtl/gaa_fitness.sv
verif/sdram_model.sv
verif/tb_gaa_fitness.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_gaa_fitness \
	-f gaa_fitness.f -o sim_gaa_fitness > build.log 2>&1 \
	&& ./obj_dir/sim_gaa_fitness > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q 'All tests passed!' sim.log 2>/dev/null && echo "simulation passed" \
	|| { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== verif/gaa_testdata.txt ====
// all hex; first value is the number of runs, then per run:
// edges nodes individuals stall listed_edges fitness_of_individual_0
// then one 128-bit partition row per node, then the listed edges as node pairs
4
// 128 individuals, no stalls
5 4 80 0 5 2
00000000000000000000000000000000
ffffffffffffffffffffffffffffffff
0123456789abcdeffedcba9876543210
a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a
0 1
1 2
2 3
3 0
0 2
// same graph with sdram stalls
5 4 80 1 5 2
00000000000000000000000000000000
ffffffffffffffffffffffffffffffff
0123456789abcdeffedcba9876543210
a5a5a5a5a5a5a5a55a5a5a5a5a5a5a5a
0 1
1 2
2 3
3 0
0 2
// new population, 5 individuals, stalls on
4 3 5 1 4 2
0000000000000000000000000000001f
00000000000000000000000000000015
0000000000000000000000000000000a
0 1
1 2
0 2
2 2
// one edge repeated 65552 times saturates individuals 0 and 2
10010 2 3 0 1 ffff
0
5
0 1
